/* Bender.yml */
package:
  name: cu_decode

sources:
  - include_dirs:
      - include
    files:
      - verilog/cu_pkg.sv
      - verilog/cu_inst_reg.sv
      - verilog/cu_imm_gen.sv
      - verilog/cu_op_decoder.sv
      - verilog/cu_branch_resolve.sv
      - verilog/cu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/cu_sva.sv
      - tests/cu_tb.sv

/* include/cu_config.svh */
`ifndef CU_CONFIG_SVH
`define CU_CONFIG_SVH

`define CU_XLEN   64
`define CU_ILEN   32
`define CU_REG_AW 5

`define CU_NOP    32'h00000013 // addi x0, x0, 0
`define CU_EBREAK 32'h00100073

// major opcodes, inst[6:0]
`define CU_OPC_OP      7'b0110011
`define CU_OPC_OP32    7'b0111011
`define CU_OPC_OPIMM   7'b0010011
`define CU_OPC_OPIMM32 7'b0011011
`define CU_OPC_LOAD    7'b0000011
`define CU_OPC_STORE   7'b0100011
`define CU_OPC_BRANCH  7'b1100011
`define CU_OPC_JAL     7'b1101111
`define CU_OPC_JALR    7'b1100111
`define CU_OPC_LUI     7'b0110111
`define CU_OPC_AUIPC   7'b0010111
`define CU_OPC_SYSTEM  7'b1110011

`endif

/* sources.f */
+incdir+include
verilog/cu_pkg.sv
verilog/cu_inst_reg.sv
verilog/cu_imm_gen.sv
verilog/cu_op_decoder.sv
verilog/cu_branch_resolve.sv
verilog/cu_top.sv
tests/cu_sva.sv
tests/cu_tb.sv

/* tests/cu_sva.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_config.svh"

module cu_sva import cu_pkg::*; (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  inst_valid,
    input cmp_result_e           cmp_out,
    input logic [`CU_REG_AW-1:0] rs1,
    input logic [`CU_REG_AW-1:0] rs2,
    input logic [`CU_REG_AW-1:0] rd,
    input logic [`CU_XLEN-1:0]   imm,
    input alu_op_e               alu_op,
    input alu_src_e              alu_src,
    input cmp_mode_e             cmp_mode,
    input cmp_src_e              cmp_src,
    input reg_src_e              reg_src,
    input pc_src_e               pc_src,
    input mem_op_e               mem_op,
    input mem_addr_src_e         mem_addr_src,
    input mem_data_src_e         mem_data_src,
    input logic                  ebreak,
    input logic                  illegal
);

    flags_exclusive_a: assert property (@(posedge clk) disable iff (!rst_n)
        !(illegal && ebreak))
        else $error("illegal and ebreak high together");

    store_keeps_reg_a: assert property (@(posedge clk) disable iff (!rst_n)
        mem_op inside {mem_sd, mem_sw, mem_sh, mem_sb} |-> reg_src == reg_keep)
        else $error("store decoded with a register write source");

    // held instruction and steady comparator leave the decode alone
    outputs_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        !inst_valid |=> (!$stable(cmp_out) || ($stable(rs1) && $stable(rs2) && $stable(rd)
            && $stable(imm) && $stable(alu_op) && $stable(alu_src) && $stable(cmp_mode)
            && $stable(cmp_src) && $stable(reg_src) && $stable(pc_src) && $stable(mem_op)
            && $stable(mem_addr_src) && $stable(mem_data_src) && $stable(ebreak)
            && $stable(illegal))))
        else $error("decode outputs changed while the instruction was held");

endmodule

bind cu_top cu_sva cu_sva_i (.*);

`default_nettype wire

/* tests/cu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_config.svh"

module cu_tb import cu_pkg::*; ();

    typedef struct {
        logic [`CU_ILEN-1:0] word;
        alu_op_e             alu_op;
        alu_src_e            alu_src;
        cmp_mode_e           mode;
        cmp_src_e            csrc;
        reg_src_e            reg_base; // before branch resolve
        mem_op_e             mem_op;
        br_cond_e            cond;
        imm_fmt_e            fmt;
        logic                eb;
        logic                il;
    } row_t;

    logic                  clk;
    logic                  rst_n;
    logic [`CU_ILEN-1:0]   inst;
    logic                  inst_valid;
    cmp_result_e           cmp_out;
    logic [`CU_REG_AW-1:0] rs1;
    logic [`CU_REG_AW-1:0] rs2;
    logic [`CU_REG_AW-1:0] rd;
    logic [`CU_XLEN-1:0]   imm;
    alu_op_e               alu_op;
    alu_src_e              alu_src;
    cmp_mode_e             cmp_mode;
    cmp_src_e              cmp_src;
    reg_src_e              reg_src;
    pc_src_e               pc_src;
    mem_op_e               mem_op;
    mem_addr_src_e         mem_addr_src;
    mem_data_src_e         mem_data_src;
    logic                  ebreak;
    logic                  illegal;

    row_t                rows[$];
    logic [`CU_ILEN-1:0] cur_word;
    int                  checks;
    int                  errors;
    logic                known;

    cu_top cu_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [`CU_XLEN-1:0] expected_imm(imm_fmt_e fmt, logic [31:0] w);
        case (fmt)
            imm_i: return longint'($signed(w[31:20]));
            imm_s: return longint'($signed({w[31:25], w[11:7]}));
            imm_b: return longint'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
            imm_u: return longint'($signed({w[31:12], 12'h000}));
            imm_j: return longint'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            default: return '0;
        endcase
    endfunction

    function automatic pc_src_e expected_pc_src(br_cond_e cond, cmp_result_e c);
        logic redirect;
        redirect = (cond == br_jump)
            || (cond == br_eq && c == cmp_eq)
            || (cond == br_ne && c != cmp_eq)
            || (cond == br_ge && c != cmp_lt) // eq or gt
            || (cond == br_lt && c == cmp_lt);
        return redirect ? pc_alu : pc_snpc;
    endfunction

    function automatic reg_src_e expected_reg_src(br_cond_e cond, reg_src_e base, cmp_result_e c);
        if (cond != br_set_lt) return base;
        return (c == cmp_lt) ? reg_one : reg_zero;
    endfunction

    function automatic logic is_store(mem_op_e op);
        return op inside {mem_sd, mem_sw, mem_sh, mem_sb};
    endfunction

    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        errors++;
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h, inst 0x%08h", name, got, exp, cur_word);
    endtask

    task automatic check_reg_field(string name, logic [`CU_REG_AW-1:0] got,
                                   logic [`CU_REG_AW-1:0] exp);
        checks++;
        if (got !== exp) report_mismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic check_alu(alu_op_e got_op, alu_op_e exp_op,
                             alu_src_e got_src, alu_src_e exp_src);
        checks += 2;
        if (got_op !== exp_op) report_mismatch("alu_op", 64'(got_op), 64'(exp_op));
        if (got_src !== exp_src) report_mismatch("alu_src", 64'(got_src), 64'(exp_src));
    endtask

    task automatic check_cmp(cmp_mode_e got_mode, cmp_mode_e exp_mode,
                             cmp_src_e got_src, cmp_src_e exp_src);
        checks += 2;
        if (got_mode !== exp_mode) report_mismatch("cmp_mode", 64'(got_mode), 64'(exp_mode));
        if (got_src !== exp_src) report_mismatch("cmp_src", 64'(got_src), 64'(exp_src));
    endtask

    task automatic check_sel(reg_src_e got_reg, reg_src_e exp_reg,
                             pc_src_e got_pc, pc_src_e exp_pc);
        checks += 2;
        if (got_reg !== exp_reg) report_mismatch("reg_src", 64'(got_reg), 64'(exp_reg));
        if (got_pc !== exp_pc) report_mismatch("pc_src", 64'(got_pc), 64'(exp_pc));
    endtask

    task automatic check_mem(mem_op_e got_op, mem_op_e exp_op,
                             mem_addr_src_e got_addr, mem_addr_src_e exp_addr,
                             mem_data_src_e got_data, mem_data_src_e exp_data);
        checks += 3;
        if (got_op !== exp_op) report_mismatch("mem_op", 64'(got_op), 64'(exp_op));
        if (got_addr !== exp_addr) begin
            report_mismatch("mem_addr_src", 64'(got_addr), 64'(exp_addr));
        end
        if (got_data !== exp_data) begin
            report_mismatch("mem_data_src", 64'(got_data), 64'(exp_data));
        end
    endtask

    task automatic check_imm(logic [`CU_XLEN-1:0] got, logic [`CU_XLEN-1:0] exp);
        checks++;
        if (got !== exp) report_mismatch("imm", got, exp);
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        checks++;
        if (got !== exp) report_mismatch(name, 64'(got), 64'(exp));
    endtask

    task automatic check_decode(row_t r, logic [`CU_ILEN-1:0] w, cmp_result_e c);
        mem_addr_src_e exp_addr;
        mem_data_src_e exp_data;
        exp_addr = (r.mem_op == mem_none) ? maddr_none : maddr_alu;
        exp_data = is_store(r.mem_op) ? mdata_rs2 : mdata_none;
        check_reg_field("rs1", rs1, w[19:15]);
        check_reg_field("rs2", rs2, w[24:20]);
        check_reg_field("rd", rd, w[11:7]);
        check_alu(alu_op, r.alu_op, alu_src, r.alu_src);
        check_cmp(cmp_mode, r.mode, cmp_src, r.csrc);
        check_sel(reg_src, expected_reg_src(r.cond, r.reg_base, c),
                  pc_src, expected_pc_src(r.cond, c));
        check_mem(mem_op, r.mem_op, mem_addr_src, exp_addr, mem_data_src, exp_data);
        check_imm(imm, expected_imm(r.fmt, w));
        check_flag("ebreak", ebreak, r.eb);
        check_flag("illegal", illegal, r.il);
    endtask

    task automatic add_row(logic [31:0] word, alu_op_e op, alu_src_e src, reg_src_e base,
                           mem_op_e mop, br_cond_e cond, imm_fmt_e fmt);
        row_t r;
        r.word     = word;
        r.alu_op   = op;
        r.alu_src  = src;
        r.mode     = cmp_unsigned;
        r.csrc     = cmp_src_rs1_rs2;
        r.reg_base = base;
        r.mem_op   = mop;
        r.cond     = cond;
        r.fmt      = fmt;
        r.eb       = 1'b0;
        r.il       = 1'b0;
        rows.push_back(r);
    endtask

    // signed compares and the immediate compare of sltiu
    task automatic set_last_cmp(cmp_mode_e mode, cmp_src_e csrc);
        rows[rows.size()-1].mode = mode;
        rows[rows.size()-1].csrc = csrc;
    endtask

    // every code inactive, only a flag set
    task automatic add_flag_row(logic [31:0] word, logic eb, logic il);
        add_row(word, alu_none, alu_src_rs1_rs2, reg_keep, mem_none, br_none, imm_none);
        rows[rows.size()-1].eb = eb;
        rows[rows.size()-1].il = il;
    endtask

    task automatic load_table();
        add_row(`CU_NOP, alu_add, alu_src_rs1_imm, reg_alu, mem_none, br_none, imm_i); // first
        add_row(32'h00000033, alu_add, alu_src_rs1_rs2, reg_alu, mem_none, br_none, imm_none);
        add_row(32'h40000033, alu_sub, alu_src_rs1_rs2, reg_alu, mem_none, br_none, imm_none);
        add_row(32'h00007033, alu_and, alu_src_rs1_rs2, reg_alu, mem_none, br_none, imm_none);
        add_row(32'h00006033, alu_or, alu_src_rs1_rs2, reg_alu, mem_none, br_none, imm_none);
        add_row(32'h00002033, alu_none, alu_src_rs1_rs2, reg_keep, mem_none, br_set_lt, imm_none);
        set_last_cmp(cmp_signed, cmp_src_rs1_rs2);
        add_row(32'h00003033, alu_none, alu_src_rs1_rs2, reg_keep, mem_none, br_set_lt, imm_none);
        add_row(32'h0000003b, alu_addw, alu_src_rs1_rs2, reg_alu, mem_none, br_none, imm_none);
        add_row(32'h4000003b, alu_subw, alu_src_rs1_rs2, reg_alu, mem_none, br_none, imm_none);
        add_row(32'h0000103b, alu_sllw, alu_src_rs1_rs2, reg_alu, mem_none, br_none, imm_none);
        add_row(32'h0200003b, alu_mulw, alu_src_rs1_rs2, reg_alu, mem_none, br_none, imm_none);
        add_row(32'h0200403b, alu_divw, alu_src_rs1_rs2, reg_alu, mem_none, br_none, imm_none);
        add_row(32'h0200603b, alu_remw, alu_src_rs1_rs2, reg_alu, mem_none, br_none, imm_none);
        add_row(32'h80000013, alu_add, alu_src_rs1_imm, reg_alu, mem_none, br_none, imm_i);
        add_row(32'h7e000013, alu_add, alu_src_rs1_imm, reg_alu, mem_none, br_none, imm_i);
        add_row(32'hf0007013, alu_and, alu_src_rs1_imm, reg_alu, mem_none, br_none, imm_i);
        add_row(32'h12004013, alu_xor, alu_src_rs1_imm, reg_alu, mem_none, br_none, imm_i);
        add_row(32'h02001013, alu_sll, alu_src_rs1_imm, reg_alu, mem_none, br_none, imm_i);
        add_row(32'h00005013, alu_srl, alu_src_rs1_imm, reg_alu, mem_none, br_none, imm_i);
        add_row(32'h40005013, alu_sra, alu_src_rs1_imm, reg_alu, mem_none, br_none, imm_i);
        add_row(32'hfe003013, alu_none, alu_src_rs1_rs2, reg_keep, mem_none, br_set_lt, imm_i);
        set_last_cmp(cmp_unsigned, cmp_src_rs1_imm);
        add_row(32'hfe00001b, alu_addw, alu_src_rs1_imm, reg_alu, mem_none, br_none, imm_i);
        add_row(32'h00003003, alu_add, alu_src_rs1_imm, reg_mem, mem_ld, br_none, imm_i);
        add_row(32'h80002003, alu_add, alu_src_rs1_imm, reg_mem, mem_lw, br_none, imm_i);
        add_row(32'h00001003, alu_add, alu_src_rs1_imm, reg_mem, mem_lh, br_none, imm_i);
        add_row(32'h00005003, alu_add, alu_src_rs1_imm, reg_mem, mem_lhu, br_none, imm_i);
        add_row(32'h00004003, alu_add, alu_src_rs1_imm, reg_mem, mem_lbu, br_none, imm_i);
        add_row(32'h00003023, alu_add, alu_src_rs1_imm, reg_keep, mem_sd, br_none, imm_s);
        add_row(32'hfe002023, alu_add, alu_src_rs1_imm, reg_keep, mem_sw, br_none, imm_s);
        add_row(32'h00001023, alu_add, alu_src_rs1_imm, reg_keep, mem_sh, br_none, imm_s);
        add_row(32'h7e000023, alu_add, alu_src_rs1_imm, reg_keep, mem_sb, br_none, imm_s);
        add_row(32'h00000063, alu_add, alu_src_imm_pc, reg_keep, mem_none, br_eq, imm_b);
        add_row(32'h80001063, alu_add, alu_src_imm_pc, reg_keep, mem_none, br_ne, imm_b);
        add_row(32'h00004063, alu_add, alu_src_imm_pc, reg_keep, mem_none, br_lt, imm_b);
        set_last_cmp(cmp_signed, cmp_src_rs1_rs2);
        add_row(32'hfe005063, alu_add, alu_src_imm_pc, reg_keep, mem_none, br_ge, imm_b);
        set_last_cmp(cmp_signed, cmp_src_rs1_rs2);
        add_row(32'h00006063, alu_add, alu_src_imm_pc, reg_keep, mem_none, br_lt, imm_b);
        add_row(32'h7e007063, alu_add, alu_src_imm_pc, reg_keep, mem_none, br_ge, imm_b);
        add_row(32'h8000006f, alu_add, alu_src_imm_pc, reg_snpc, mem_none, br_jump, imm_j);
        add_row(32'h4000006f, alu_add, alu_src_imm_pc, reg_snpc, mem_none, br_jump, imm_j);
        add_row(32'hff000067, alu_add_clr_lsb, alu_src_rs1_imm, reg_snpc, mem_none,
                br_jump, imm_i);
        add_row(32'h80000037, alu_none, alu_src_rs1_rs2, reg_imm, mem_none, br_none, imm_u);
        add_row(32'h12345037, alu_none, alu_src_rs1_rs2, reg_imm, mem_none, br_none, imm_u);
        add_row(32'habcde017, alu_add, alu_src_imm_pc, reg_alu, mem_none, br_none, imm_u);
        add_flag_row(`CU_EBREAK, 1'b1, 1'b0);
        add_flag_row(32'h00000000, 1'b0, 1'b1);
        add_flag_row(32'h00000073, 1'b0, 1'b1); // ecall is not in the table
        add_flag_row(32'h02001033, 1'b0, 1'b1);
    endtask

    task automatic wait_outputs_known(output logic ok);
        int n;
        n = 0;
        while ($isunknown({alu_op, reg_src, pc_src, mem_op, ebreak, illegal}) && n < 8) begin
            @(negedge clk);
            n++;
        end
        ok = !$isunknown({alu_op, reg_src, pc_src, mem_op, ebreak, illegal});
    endtask

    task automatic run_table();
        logic [`CU_ILEN-1:0] w;
        logic [31:0]         r;
        foreach (rows[i]) begin
            w = rows[i].word;
            if (!rows[i].eb && !rows[i].il) begin
                r = $urandom;
                w[11:7]  = r[4:0];
                w[19:15] = r[9:5];
                w[24:20] = r[14:10];
            end
            cur_word   = w;
            inst       = w;
            inst_valid = 1'b1;
            cmp_out    = cmp_eq;
            @(negedge clk);
            check_decode(rows[i], w, cmp_eq);
            inst_valid = 1'b0;
            inst       = ~w; // must not reach the register
            if (rows[i].cond != br_none) begin
                cmp_out = cmp_lt;
                @(negedge clk);
                check_decode(rows[i], w, cmp_lt);
                cmp_out = cmp_gt;
                @(negedge clk);
                check_decode(rows[i], w, cmp_gt);
            end else begin
                @(negedge clk);
                check_decode(rows[i], w, cmp_eq);
            end
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        inst       = '0;
        inst_valid = 1'b0;
        cmp_out    = cmp_eq;
        checks     = 0;
        errors     = 0;
        cur_word   = `CU_NOP;
        void'($urandom(32'hfd44543d));
        load_table();
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        wait_outputs_known(known);
        if (!known) begin
            $display("decode outputs stayed unknown after reset release");
            errors++;
        end else begin
            check_decode(rows[0], `CU_NOP, cmp_eq); // reset value is nop
            run_table();
        end
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/cu_branch_resolve.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_branch_resolve import cu_pkg::*; (
    input  br_cond_e    br_cond,
    input  reg_src_e    base_reg_src,
    input  cmp_result_e cmp_out,
    output pc_src_e     pc_src,
    output reg_src_e    reg_src
);

    logic taken;

    always_comb begin
        case (br_cond)
            br_jump: taken = 1'b1;
            br_eq:   taken = (cmp_out == cmp_eq);
            br_ne:   taken = (cmp_out != cmp_eq);
            br_ge:   taken = (cmp_out == cmp_eq) || (cmp_out == cmp_gt);
            br_lt:   taken = (cmp_out == cmp_lt);
            default: taken = 1'b0; // none and set_lt never redirect
        endcase
    end

    assign pc_src = taken ? pc_alu : pc_snpc;

    // slt family writes the compare outcome as 0 or 1
    always_comb begin
        if (br_cond == br_set_lt) begin
            reg_src = (cmp_out == cmp_lt) ? reg_one : reg_zero;
        end else begin
            reg_src = base_reg_src;
        end
    end

endmodule

`default_nettype wire

/* verilog/cu_imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_config.svh"

module cu_imm_gen import cu_pkg::*; (
    input  logic [`CU_ILEN-1:0] inst_q,
    input  imm_fmt_e            imm_fmt,
    output logic [`CU_XLEN-1:0] imm
);

    logic sign;

    assign sign = inst_q[31];

    always_comb begin
        case (imm_fmt)
            imm_i: imm = {{(`CU_XLEN-12){sign}}, inst_q[31:20]};
            imm_s: imm = {{(`CU_XLEN-12){sign}}, inst_q[31:25], inst_q[11:7]};
            imm_b: begin
                imm = {{(`CU_XLEN-12){sign}}, inst_q[7], inst_q[30:25],
                       inst_q[11:8], 1'b0}; // bit 12 is the sign
            end
            imm_u: imm = {{(`CU_XLEN-32){sign}}, inst_q[31:12], 12'b0};
            imm_j: begin
                imm = {{(`CU_XLEN-20){sign}}, inst_q[19:12], inst_q[20],
                       inst_q[30:21], 1'b0};
            end
            default: imm = '0; // r-type and friends
        endcase
    end

endmodule

`default_nettype wire

/* verilog/cu_inst_reg.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_config.svh"

module cu_inst_reg (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`CU_ILEN-1:0]   inst,
    input  logic                  inst_valid,
    output logic [`CU_ILEN-1:0]   inst_q,
    output logic [`CU_REG_AW-1:0] rs1,
    output logic [`CU_REG_AW-1:0] rs2,
    output logic [`CU_REG_AW-1:0] rd
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_q <= `CU_NOP;
        end else if (inst_valid) begin
            inst_q <= inst; // hold otherwise
        end
    end

    assign rs1 = inst_q[19:15];
    assign rs2 = inst_q[24:20];
    assign rd  = inst_q[11:7];

endmodule

`default_nettype wire

/* verilog/cu_op_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_config.svh"

module cu_op_decoder import cu_pkg::*; (
    input  logic [`CU_ILEN-1:0] inst_q,
    output alu_op_e             alu_op,
    output alu_src_e            alu_src,
    output cmp_mode_e           cmp_mode,
    output cmp_src_e            cmp_src,
    output reg_src_e            reg_src,
    output mem_op_e             mem_op,
    output mem_addr_src_e       mem_addr_src,
    output mem_data_src_e       mem_data_src,
    output br_cond_e            br_cond,
    output imm_fmt_e            imm_fmt,
    output logic                ebreak,
    output logic                illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst_q[6:0];
    assign funct3 = inst_q[14:12];
    assign funct7 = inst_q[31:25];

    always_comb begin
        alu_op       = alu_none;
        alu_src      = alu_src_rs1_rs2;
        cmp_mode     = cmp_unsigned;
        cmp_src      = cmp_src_rs1_rs2;
        reg_src      = reg_keep;
        mem_op       = mem_none;
        mem_addr_src = maddr_none;
        mem_data_src = mdata_none;
        br_cond      = br_none;
        imm_fmt      = imm_none;
        ebreak       = 1'b0;
        illegal      = 1'b0;
        case (opcode)
            `CU_OPC_OP: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op = alu_add;
                    {7'b0100000, 3'b000}: alu_op = alu_sub;
                    {7'b0000000, 3'b111}: alu_op = alu_and;
                    {7'b0000000, 3'b110}: alu_op = alu_or;
                    {7'b0000000, 3'b010}: begin // slt
                        cmp_mode = cmp_signed;
                        br_cond  = br_set_lt;
                    end
                    {7'b0000000, 3'b011}: br_cond = br_set_lt; // sltu
                    default: illegal = 1'b1;
                endcase
                if (!illegal && br_cond == br_none) reg_src = reg_alu;
            end
            `CU_OPC_OP32: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op = alu_addw;
                    {7'b0100000, 3'b000}: alu_op = alu_subw;
                    {7'b0000000, 3'b001}: alu_op = alu_sllw;
                    {7'b0000001, 3'b000}: alu_op = alu_mulw;
                    {7'b0000001, 3'b100}: alu_op = alu_divw;
                    {7'b0000001, 3'b110}: alu_op = alu_remw;
                    default: illegal = 1'b1;
                endcase
                if (!illegal) reg_src = reg_alu;
            end
            `CU_OPC_OPIMM: begin
                case (funct3)
                    3'b000: alu_op = alu_add;
                    3'b001: if (funct7[6:1] == 6'b000000) alu_op = alu_sll; else illegal = 1'b1;
                    3'b011: begin // sltiu
                        cmp_src = cmp_src_rs1_imm;
                        br_cond = br_set_lt;
                    end
                    3'b100: alu_op = alu_xor;
                    3'b101: begin
                        if (funct7[6:1] == 6'b000000) alu_op = alu_srl;
                        else if (funct7[6:1] == 6'b010000) alu_op = alu_sra;
                        else illegal = 1'b1;
                    end
                    3'b111: alu_op = alu_and;
                    default: illegal = 1'b1;
                endcase
                if (!illegal) imm_fmt = imm_i;
                if (!illegal && br_cond == br_none) begin
                    alu_src = alu_src_rs1_imm;
                    reg_src = reg_alu;
                end
            end
            `CU_OPC_OPIMM32: begin
                if (funct3 == 3'b000) begin // addiw
                    alu_op  = alu_addw;
                    alu_src = alu_src_rs1_imm;
                    reg_src = reg_alu;
                    imm_fmt = imm_i;
                end else begin
                    illegal = 1'b1;
                end
            end
            `CU_OPC_LOAD: begin
                case (funct3)
                    3'b011: mem_op = mem_ld;
                    3'b010: mem_op = mem_lw;
                    3'b001: mem_op = mem_lh;
                    3'b101: mem_op = mem_lhu;
                    3'b100: mem_op = mem_lbu;
                    default: illegal = 1'b1;
                endcase
                if (!illegal) begin
                    alu_op       = alu_add; // rs1 + offset
                    alu_src      = alu_src_rs1_imm;
                    reg_src      = reg_mem;
                    mem_addr_src = maddr_alu;
                    imm_fmt      = imm_i;
                end
            end
            `CU_OPC_STORE: begin
                case (funct3)
                    3'b011: mem_op = mem_sd;
                    3'b010: mem_op = mem_sw;
                    3'b001: mem_op = mem_sh;
                    3'b000: mem_op = mem_sb;
                    default: illegal = 1'b1;
                endcase
                if (!illegal) begin
                    alu_op       = alu_add;
                    alu_src      = alu_src_rs1_imm;
                    mem_addr_src = maddr_alu;
                    mem_data_src = mdata_rs2;
                    imm_fmt      = imm_s;
                end
            end
            `CU_OPC_BRANCH: begin
                case (funct3)
                    3'b000: br_cond = br_eq;
                    3'b001: br_cond = br_ne;
                    3'b100: begin
                        br_cond  = br_lt;
                        cmp_mode = cmp_signed;
                    end
                    3'b101: begin
                        br_cond  = br_ge;
                        cmp_mode = cmp_signed;
                    end
                    3'b110: br_cond = br_lt; // bltu
                    3'b111: br_cond = br_ge; // bgeu
                    default: illegal = 1'b1;
                endcase
                if (!illegal) begin
                    alu_op  = alu_add; // target pc + imm
                    alu_src = alu_src_imm_pc;
                    imm_fmt = imm_b;
                end
            end
            `CU_OPC_JAL: begin
                alu_op  = alu_add;
                alu_src = alu_src_imm_pc;
                reg_src = reg_snpc;
                br_cond = br_jump;
                imm_fmt = imm_j;
            end
            `CU_OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    alu_op  = alu_add_clr_lsb;
                    alu_src = alu_src_rs1_imm;
                    reg_src = reg_snpc;
                    br_cond = br_jump;
                    imm_fmt = imm_i;
                end else begin
                    illegal = 1'b1;
                end
            end
            `CU_OPC_LUI: begin
                reg_src = reg_imm;
                imm_fmt = imm_u;
            end
            `CU_OPC_AUIPC: begin
                alu_op  = alu_add;
                alu_src = alu_src_imm_pc;
                reg_src = reg_alu;
                imm_fmt = imm_u;
            end
            `CU_OPC_SYSTEM: begin
                if (inst_q == `CU_EBREAK) ebreak = 1'b1; // exact word only
                else illegal = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/cu_pkg.sv */
`default_nettype none

package cu_pkg;

    typedef enum logic [4:0] {
        alu_none        = 5'b00000,
        alu_add         = 5'b00001,
        alu_add_clr_lsb = 5'b00010, // jalr target
        alu_sll         = 5'b00011,
        alu_addw        = 5'b00100,
        alu_sub         = 5'b00101,
        alu_sra         = 5'b00110,
        alu_and         = 5'b00111,
        alu_sllw        = 5'b01000,
        alu_xor         = 5'b01001,
        alu_or          = 5'b01010,
        alu_srl         = 5'b01011,
        alu_mulw        = 5'b01100,
        alu_divw        = 5'b10001,
        alu_remw        = 5'b10101,
        alu_subw        = 5'b11001
    } alu_op_e;

    typedef enum logic [2:0] {
        alu_src_rs1_rs2  = 3'b000,
        alu_src_rs1_imm  = 3'b001,
        alu_src_rs1_pc   = 3'b010,
        alu_src_rs1_snpc = 3'b011,
        alu_src_imm_pc   = 3'b100,
        alu_src_imm_snpc = 3'b101
    } alu_src_e;

    typedef enum logic [0:0] {cmp_unsigned = 1'b0, cmp_signed = 1'b1} cmp_mode_e;

    typedef enum logic [1:0] {cmp_src_rs1_rs2 = 2'b00, cmp_src_rs1_imm = 2'b01} cmp_src_e;

    typedef enum logic [1:0] {cmp_eq = 2'b00, cmp_lt = 2'b01, cmp_gt = 2'b10} cmp_result_e;

    typedef enum logic [2:0] {
        reg_keep, reg_alu, reg_pc, reg_snpc, reg_imm, reg_mem, reg_zero, reg_one
    } reg_src_e;

    typedef enum logic [1:0] {pc_snpc = 2'b00, pc_alu = 2'b01} pc_src_e;

    typedef enum logic [3:0] {
        mem_none = 4'b0000,
        mem_ld   = 4'b0001,
        mem_lw   = 4'b0010,
        mem_lh   = 4'b0011,
        mem_lhu  = 4'b0110,
        mem_lbu  = 4'b0111,
        mem_sd   = 4'b1000, // msb set for stores
        mem_sw   = 4'b1001,
        mem_sh   = 4'b1010,
        mem_sb   = 4'b1011
    } mem_op_e;

    typedef enum logic [2:0] {maddr_none = 3'b000, maddr_alu = 3'b001} mem_addr_src_e;

    typedef enum logic [2:0] {mdata_none = 3'b000, mdata_rs2 = 3'b010} mem_data_src_e;

    typedef enum logic [2:0] {
        br_none, br_jump, br_eq, br_ne, br_ge, br_lt, br_set_lt
    } br_cond_e;

    typedef enum logic [2:0] {imm_none, imm_i, imm_s, imm_b, imm_u, imm_j} imm_fmt_e;

endpackage

`default_nettype wire

/* verilog/cu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cu_config.svh"

module cu_top import cu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`CU_ILEN-1:0]   inst,
    input  logic                  inst_valid,
    input  cmp_result_e           cmp_out,
    output logic [`CU_REG_AW-1:0] rs1,
    output logic [`CU_REG_AW-1:0] rs2,
    output logic [`CU_REG_AW-1:0] rd,
    output logic [`CU_XLEN-1:0]   imm,
    output alu_op_e               alu_op,
    output alu_src_e              alu_src,
    output cmp_mode_e             cmp_mode,
    output cmp_src_e              cmp_src,
    output reg_src_e              reg_src,
    output pc_src_e               pc_src,
    output mem_op_e               mem_op,
    output mem_addr_src_e         mem_addr_src,
    output mem_data_src_e         mem_data_src,
    output logic                  ebreak,
    output logic                  illegal
);

    logic [`CU_ILEN-1:0] inst_q;
    reg_src_e            base_reg_src;
    br_cond_e            br_cond;
    imm_fmt_e            imm_fmt;

    cu_inst_reg cu_inst_reg_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst       (inst),
        .inst_valid (inst_valid),
        .inst_q     (inst_q),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd)
    );

    cu_op_decoder cu_op_decoder_i (
        .inst_q       (inst_q),
        .alu_op       (alu_op),
        .alu_src      (alu_src),
        .cmp_mode     (cmp_mode),
        .cmp_src      (cmp_src),
        .reg_src      (base_reg_src), // before slt / branch override
        .mem_op       (mem_op),
        .mem_addr_src (mem_addr_src),
        .mem_data_src (mem_data_src),
        .br_cond      (br_cond),
        .imm_fmt      (imm_fmt),
        .ebreak       (ebreak),
        .illegal      (illegal)
    );

    cu_imm_gen cu_imm_gen_i (
        .inst_q  (inst_q),
        .imm_fmt (imm_fmt),
        .imm     (imm)
    );

    cu_branch_resolve cu_branch_resolve_i (
        .br_cond      (br_cond),
        .base_reg_src (base_reg_src),
        .cmp_out      (cmp_out),
        .pc_src       (pc_src),
        .reg_src      (reg_src)
    );

endmodule

`default_nettype wire
